//--- core_top.f
hdl/core_isa_pkg.sv
hdl/core_pipe_pkg.sv
hdl/fetch_buffer.sv
hdl/instr_decoder.sv
hdl/bypass_ctrl.sv
hdl/operand_read_port.sv
hdl/ex_stage.sv
hdl/wb_stage.sv
hdl/core_top.sv
sim/tb_core_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the core_top testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_core_top \
  -f core_top.f --Mdir "$BUILD_DIR" -o Vtb_core_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_core_top" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
echo "Simulation passed"
exit 0

//--- sim/tb_core_top.sv
/*
 * Testbench for core_top. Streams directed and random programs through the
 * credit interface, models a data memory with random latency and checks
 * every retirement against a sequential reference model.
 */

`timescale 1ns/1ps

module tb_core_top import core_isa_pkg::*; ();

  localparam int FETCH_DEPTH    = 4;
  localparam int SEED           = 65269;
  localparam int CREDIT_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT  = 4000;
  localparam int RANDOM_COUNT   = 300;

  // Encodings
  localparam logic [6:0] OPC_REG  = 7'h33;
  localparam logic [6:0] OPC_IMM  = 7'h13;
  localparam logic [6:0] OPC_LOAD = 7'h03;
  localparam logic [2:0] FN3_ADD  = 3'b000;
  localparam logic [2:0] FN3_XOR  = 3'b100;
  localparam logic [2:0] FN3_AND  = 3'b111;
  localparam logic [2:0] FN3_LW   = 3'b010;
  localparam logic [6:0] FN7_BASE = 7'h00;
  localparam logic [6:0] FN7_SUB  = 7'h20;

  // One expected retirement
  typedef struct packed {
    logic     we;
    rf_addr_t waddr;
    word_t    wdata;
  } trace_t;

  logic     clk = 1'b0;
  logic     rst_n_i;
  logic     instr_valid_i;
  word_t    instr_i;
  logic     credit_o;
  logic     dmem_req_o;
  word_t    dmem_addr_o;
  logic     dmem_rvalid_i = 1'b0;
  word_t    dmem_rdata_i = '0;
  logic     wb_valid_o;
  logic     wb_we_o;
  rf_addr_t wb_waddr_o;
  word_t    wb_wdata_o;

  // Program, idle gaps and expected trace
  word_t  prog[$];
  string  prog_tag[$];
  int     prog_idle[$];
  trace_t expected[$];

  int    sent = 0;
  int    returned_q = 0;
  int    pushed_q = 0;
  int    retired_q = 0;
  logic  mem_busy_q = 1'b0;
  int    mem_wait_q = 0;
  word_t mem_addr_q = '0;

  core_top #(.FETCH_DEPTH(FETCH_DEPTH)) UUT (
    .clk(clk), .rst_n_i(rst_n_i),
    .instr_valid_i(instr_valid_i), .instr_i(instr_i), .credit_o(credit_o),
    .dmem_req_o(dmem_req_o), .dmem_addr_o(dmem_addr_o),
    .dmem_rvalid_i(dmem_rvalid_i), .dmem_rdata_i(dmem_rdata_i),
    .wb_valid_o(wb_valid_o), .wb_we_o(wb_we_o),
    .wb_waddr_o(wb_waddr_o), .wb_wdata_o(wb_wdata_o)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input word_t exp_val, input word_t act_val);
    if (exp_val !== act_val) begin
      $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp_val, act_val);
      abort_run("value mismatch");
    end
  endtask

  // Memory contents mixed from every address bit
  function automatic word_t mem_word(input word_t addr);
    return (addr * 32'h9E37_79B1) ^ {addr[7:0], addr[31:8]} ^ 32'hC0DE_5A5A;
  endfunction

  function automatic word_t r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                        input int rd, input int rs1, input int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_REG};
  endfunction

  function automatic word_t i_type_word(input logic [6:0] opc, input logic [2:0] f3,
                                        input int rd, input int rs1, input logic [11:0] imm);
    return {imm, 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic void add_instr(input string tag, input word_t w, input int idle);
    prog.push_back(w);
    prog_tag.push_back(tag);
    prog_idle.push_back(idle);
  endfunction

  ////////////////////////////////////////
  // Programs and reference model
  ////////////////////////////////////////

  task automatic build_program();
    word_t w;
    int    r;
    int    n;
    int    kind;
    int    rd;
    int    rs1;
    int    rs2;
    int    idle;
    logic [11:0] imm;
    // Every register gets a known value first
    for (r = 1; r < 32; r++) begin
      add_instr("reg_init", i_type_word(OPC_IMM, FN3_ADD, r, 0, 12'($urandom())), 0);
    end
    // Back-to-back dependencies for EX and WB forwarding
    add_instr("alu_chain", r_type_word(FN7_BASE, FN3_ADD, 1, 1, 2), 0);
    add_instr("alu_chain", r_type_word(FN7_BASE, FN3_ADD, 1, 1, 1), 0);
    add_instr("alu_chain", r_type_word(FN7_SUB, FN3_ADD, 3, 1, 2), 0);
    add_instr("alu_chain", r_type_word(FN7_BASE, FN3_XOR, 4, 3, 1), 0);
    add_instr("alu_chain", r_type_word(FN7_BASE, FN3_AND, 5, 4, 3), 0);
    add_instr("alu_chain", i_type_word(OPC_IMM, FN3_ADD, 5, 5, 12'hFF9), 0);
    add_instr("alu_chain", r_type_word(FN7_BASE, FN3_ADD, 6, 5, 4), 0);
    // Load results used right away and one slot later
    add_instr("load_use", i_type_word(OPC_LOAD, FN3_LW, 7, 1, 12'h010), 0);
    add_instr("load_use", r_type_word(FN7_BASE, FN3_ADD, 8, 7, 7), 0);
    add_instr("load_use", i_type_word(OPC_LOAD, FN3_LW, 9, 7, 12'h000), 0);
    add_instr("load_use", i_type_word(OPC_LOAD, FN3_LW, 10, 9, 12'h7FC), 0);
    add_instr("load_use", i_type_word(OPC_IMM, FN3_ADD, 11, 10, 12'h001), 0);
    add_instr("load_use", i_type_word(OPC_LOAD, FN3_LW, 12, 2, 12'h800), 0);
    add_instr("load_use", r_type_word(FN7_BASE, FN3_ADD, 13, 3, 4), 0);
    add_instr("load_use", r_type_word(FN7_BASE, FN3_XOR, 14, 12, 13), 0);
    // Register 0 as source and as target
    add_instr("reg_zero", i_type_word(OPC_IMM, FN3_ADD, 0, 1, 12'h123), 0);
    add_instr("reg_zero", r_type_word(FN7_BASE, FN3_ADD, 15, 0, 1), 0);
    add_instr("reg_zero", i_type_word(OPC_LOAD, FN3_LW, 0, 2, 12'h020), 0);
    add_instr("reg_zero", r_type_word(FN7_BASE, FN3_ADD, 16, 0, 0), 0);
    add_instr("reg_zero", r_type_word(FN7_SUB, FN3_ADD, 0, 1, 2), 0);
    add_instr("reg_zero", r_type_word(FN7_BASE, FN3_XOR, 17, 0, 17), 0);
    // Bad opcodes and function codes followed by reads of their targets
    add_instr("illegal", 32'hFFFF_FFFF, 0);
    add_instr("illegal", r_type_word(7'h01, FN3_ADD, 18, 1, 2), 0);
    add_instr("illegal", i_type_word(OPC_IMM, 3'b001, 19, 1, 12'h004), 0);
    add_instr("illegal", i_type_word(OPC_LOAD, 3'b000, 20, 1, 12'h000), 0);
    add_instr("illegal", 32'h1234_560B, 0);
    add_instr("illegal", r_type_word(FN7_BASE, FN3_ADD, 21, 18, 19), 0);
    add_instr("illegal", r_type_word(FN7_BASE, FN3_ADD, 22, 20, 0), 0);
    // Random mix over a small register range for many hazards
    for (n = 0; n < RANDOM_COUNT; n++) begin
      kind = $urandom_range(9, 0);
      rd   = $urandom_range(7, 0);
      rs1  = $urandom_range(7, 0);
      rs2  = $urandom_range(7, 0);
      imm  = 12'($urandom());
      case (kind)
        0, 1:    w = r_type_word(FN7_BASE, FN3_ADD, rd, rs1, rs2);
        2:       w = r_type_word(FN7_SUB, FN3_ADD, rd, rs1, rs2);
        3:       w = r_type_word(FN7_BASE, FN3_AND, rd, rs1, rs2);
        4:       w = r_type_word(FN7_BASE, FN3_XOR, rd, rs1, rs2);
        5, 6:    w = i_type_word(OPC_IMM, FN3_ADD, rd, rs1, imm);
        7, 8:    w = i_type_word(OPC_LOAD, FN3_LW, rd, rs1, imm);
        default: begin
          w = $urandom();
          if (w[0]) begin
            w[6:0] = 7'h5B;
          end else begin
            w = r_type_word(7'h41, FN3_XOR, rd, rs1, rs2);
          end
        end
      endcase
      // Sender goes idle now and then
      idle = 0;
      if ($urandom_range(3, 0) == 0) begin
        idle = $urandom_range(4, 1);
      end
      add_instr("random", w, idle);
    end
  endtask

  // Runs the program in order and records each retirement
  function automatic void build_expected();
    word_t      ref_rf [32];
    word_t      w;
    word_t      a;
    word_t      b;
    word_t      imm;
    word_t      val;
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    rf_addr_t   rd;
    logic       legal;
    trace_t     ent;
    for (int r = 0; r < 32; r++) begin
      ref_rf[r] = '0;
    end
    foreach (prog[i]) begin
      w     = prog[i];
      opc   = w[6:0];
      f3    = w[14:12];
      f7    = w[31:25];
      rd    = w[11:7];
      a     = ref_rf[w[19:15]];
      b     = ref_rf[w[24:20]];
      imm   = {{20{w[31]}}, w[31:20]};
      legal = 1'b1;
      val   = '0;
      case (opc)
        OPC_REG: begin
          if (f7 == FN7_BASE && f3 == FN3_ADD) val = a + b;
          else if (f7 == FN7_SUB && f3 == FN3_ADD) val = a - b;
          else if (f7 == FN7_BASE && f3 == FN3_AND) val = a & b;
          else if (f7 == FN7_BASE && f3 == FN3_XOR) val = a ^ b;
          else legal = 1'b0;
        end
        OPC_IMM: begin
          if (f3 == FN3_ADD) val = a + imm;
          else legal = 1'b0;
        end
        OPC_LOAD: begin
          if (f3 == FN3_LW) val = mem_word(a + imm);
          else legal = 1'b0;
        end
        default: legal = 1'b0;
      endcase
      ent.we    = legal && (rd != '0);
      ent.waddr = rd;
      ent.wdata = val;
      if (ent.we) begin
        ref_rf[rd] = val;
      end
      expected.push_back(ent);
    end
  endfunction

  ////////////////////////////////////////
  // Memory model and monitors
  ////////////////////////////////////////

  // Answers each load after 1 to 4 cycles
  always @(posedge clk) begin : dmem_model
    int delay;
    if (!rst_n_i) begin
      dmem_rvalid_i <= 1'b0;
      mem_busy_q    <= 1'b0;
    end else if (dmem_rvalid_i) begin
      // Request seen here belongs to the load just answered and is still held
      check_value("dmem request at response", 32'h1, 32'(dmem_req_o));
      check_value("dmem address at response", mem_addr_q, dmem_addr_o);
      dmem_rvalid_i <= 1'b0;
    end else if (mem_busy_q) begin
      check_value("dmem request hold", 32'h1, 32'(dmem_req_o));
      check_value("dmem address hold", mem_addr_q, dmem_addr_o);
      if (mem_wait_q == 1) begin
        mem_busy_q    <= 1'b0;
        dmem_rvalid_i <= 1'b1;
        dmem_rdata_i  <= mem_word(mem_addr_q);
      end else begin
        mem_wait_q <= mem_wait_q - 1;
      end
    end else if (dmem_req_o) begin
      delay      = $urandom_range(4, 1);
      mem_addr_q <= dmem_addr_o;
      if (delay == 1) begin
        dmem_rvalid_i <= 1'b1;
        dmem_rdata_i  <= mem_word(dmem_addr_o);
      end else begin
        mem_busy_q <= 1'b1;
        mem_wait_q <= delay - 1;
      end
    end
  end

  // Push and credit bookkeeping
  always @(posedge clk) begin : credit_monitor
    if (rst_n_i) begin
      if (credit_o) returned_q <= returned_q + 1;
      if (instr_valid_i) pushed_q <= pushed_q + 1;
      if (pushed_q - returned_q > FETCH_DEPTH) begin
        abort_run("sender pushed without holding a credit");
      end
      if (returned_q > pushed_q) begin
        abort_run("credit returned for an instruction that was never pushed");
      end
    end
  end

  // Compares each retirement with the reference trace
  always @(posedge clk) begin : retire_check
    trace_t exp_t;
    string  name;
    if (rst_n_i && wb_valid_o) begin
      if (retired_q >= expected.size()) begin
        abort_run("retirement seen after the last instruction of the program");
      end else begin
        exp_t = expected[retired_q];
        name  = $sformatf("%s #%0d", prog_tag[retired_q], retired_q);
        check_value({name, " we"}, 32'(exp_t.we), 32'(wb_we_o));
        if (exp_t.we) begin
          check_value({name, " waddr"}, 32'(exp_t.waddr), 32'(wb_waddr_o));
          check_value({name, " wdata"}, exp_t.wdata, wb_wdata_o);
        end
        retired_q <= retired_q + 1;
      end
    end
  end

  // Waits out the idle gap and a credit, then pushes one word
  task automatic push_instr(input word_t w, input int idle);
    int waited;
    waited = 0;
    repeat (idle) begin
      @(posedge clk);
      instr_valid_i <= 1'b0;
    end
    @(posedge clk);
    while (sent - returned_q >= FETCH_DEPTH) begin
      instr_valid_i <= 1'b0;
      waited++;
      if (waited > CREDIT_TIMEOUT) abort_run("timeout waiting for a fetch credit");
      else @(posedge clk);
    end
    instr_valid_i <= 1'b1;
    instr_i       <= w;
    sent++;
  endtask

  task automatic drain_retirements();
    int waited;
    waited = 0;
    while (retired_q < expected.size()) begin
      waited++;
      if (waited > DRAIN_TIMEOUT) abort_run("timeout waiting for all instructions to retire");
      else @(posedge clk);
    end
  endtask

  task automatic collect_credits();
    int waited;
    waited = 0;
    while (returned_q < sent) begin
      waited++;
      if (waited > CREDIT_TIMEOUT) abort_run("timeout waiting for the last credits");
      else @(posedge clk);
    end
  endtask

  initial begin : main
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    void'($urandom(SEED));
    build_program();
    build_expected();
    repeat (16) @(posedge clk);
    check_value("reset credit_o", 32'h0, 32'(credit_o));
    check_value("reset dmem_req_o", 32'h0, 32'(dmem_req_o));
    check_value("reset wb_valid_o", 32'h0, 32'(wb_valid_o));
    rst_n_i <= 1'b1;
    foreach (prog[i]) begin
      push_instr(prog[i], prog_idle[i]);
    end
    @(posedge clk);
    instr_valid_i <= 1'b0;
    drain_retirements();
    collect_credits();
    // Idle pipeline where no late credit or retirement may appear
    repeat (2 * FETCH_DEPTH) @(posedge clk);
    check_value("credits held", 32'(FETCH_DEPTH), 32'(FETCH_DEPTH - (sent - returned_q)));
    check_value("push count", 32'(prog.size()), 32'(pushed_q));
    check_value("retire count", 32'(pushed_q), 32'(retired_q));
    $display("TEST OK");
    $finish;
  end

endmodule

//--- hdl/core_top.sv
/*
 * Top level of the ID/EX/WB pipeline. Instruction words enter through
 * the credit-based fetch buffer; loads go out on the data memory port.
 */

`timescale 1ns/1ps

module core_top import core_isa_pkg::*, core_pipe_pkg::*; #(
  parameter int unsigned FETCH_DEPTH = 4
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     instr_valid_i,
  input  word_t    instr_i,
  output logic     credit_o,
  output logic     dmem_req_o,
  output word_t    dmem_addr_o,
  input  logic     dmem_rvalid_i,
  input  word_t    dmem_rdata_i,
  output logic     wb_valid_o,
  output logic     wb_we_o,
  output rf_addr_t wb_waddr_o,
  output word_t    wb_wdata_o
);

  // Fetch to decode
  logic        head_valid;
  word_t       head_instr;
  logic        pop;
  // Decode outputs
  logic [1:0]  rf_re;
  rf_addr_t    rf_raddr [2];
  rf_addr_t    rf_waddr;
  logic        rf_we;
  logic        lsu_en;
  logic        illegal;
  alu_op_e     alu_op;
  word_t       imm;
  // Hazards and operands
  ctrl_byp_t   ctrl_byp;
  fwd_sel_e    fw_sel [2];
  word_t       operand [2];
  // Pipeline state
  id_ex_pipe_t id_ex_pipe;
  ex_wb_pipe_t ex_wb_pipe;
  word_t       ex_result;
  word_t       wb_fw;
  word_t       rf_data [32];
  logic        wb_ready;

  // ID consumes the head when nothing stalls
  assign pop = head_valid && !ctrl_byp.load_stall && wb_ready;

  assign fw_sel[0] = ctrl_byp.operand_a_fw_mux_sel;
  assign fw_sel[1] = ctrl_byp.operand_b_fw_mux_sel;

  fetch_buffer #(.FETCH_DEPTH(FETCH_DEPTH)) u_fetch_buffer (
    .clk(clk), .rst_n_i(rst_n_i),
    .push_valid_i(instr_valid_i), .push_instr_i(instr_i), .pop_i(pop),
    .head_valid_o(head_valid), .head_instr_o(head_instr), .credit_o(credit_o)
  );

  instr_decoder u_instr_decoder (
    .instr_valid_i(head_valid), .instr_i(head_instr),
    .rf_re_o(rf_re), .rf_raddr_o(rf_raddr), .rf_waddr_o(rf_waddr),
    .rf_we_o(rf_we), .lsu_en_o(lsu_en), .illegal_o(illegal),
    .alu_op_o(alu_op), .imm_o(imm)
  );

  bypass_ctrl u_bypass_ctrl (
    .rf_re_i(rf_re), .rf_raddr_i(rf_raddr), .illegal_i(illegal),
    .id_ex_pipe_i(id_ex_pipe), .ex_wb_pipe_i(ex_wb_pipe),
    .wb_ready_i(wb_ready), .ctrl_byp_o(ctrl_byp)
  );

  // One read port per source operand
  for (genvar i = 0; i < 2; i++) begin : gen_read_port
    operand_read_port u_operand_read_port (
      .raddr_i(rf_raddr[i]), .sel_i(fw_sel[i]), .rf_data_i(rf_data),
      .ex_fw_i(ex_result), .wb_fw_i(wb_fw), .operand_o(operand[i])
    );
  end

  ex_stage u_ex_stage (
    .clk(clk), .rst_n_i(rst_n_i), .id_valid_i(head_valid),
    .rf_we_i(rf_we), .lsu_en_i(lsu_en), .rf_waddr_i(rf_waddr),
    .alu_op_i(alu_op), .rs2_re_i(rf_re[1]),
    .operand_a_i(operand[0]), .operand_b_i(operand[1]), .imm_i(imm),
    .deassert_we_i(ctrl_byp.deassert_we), .load_stall_i(ctrl_byp.load_stall),
    .wb_ready_i(wb_ready), .id_ex_pipe_o(id_ex_pipe), .ex_wb_pipe_o(ex_wb_pipe),
    .ex_result_o(ex_result)
  );

  wb_stage u_wb_stage (
    .clk(clk), .rst_n_i(rst_n_i), .ex_wb_pipe_i(ex_wb_pipe),
    .dmem_req_o(dmem_req_o), .dmem_addr_o(dmem_addr_o),
    .dmem_rvalid_i(dmem_rvalid_i), .dmem_rdata_i(dmem_rdata_i),
    .wb_ready_o(wb_ready), .wb_fw_o(wb_fw), .rf_data_o(rf_data),
    .wb_valid_o(wb_valid_o), .wb_we_o(wb_we_o),
    .wb_waddr_o(wb_waddr_o), .wb_wdata_o(wb_wdata_o)
  );

endmodule

//--- hdl/wb_stage.sv
/*
 * Writeback stage. Holds the register file, issues loads to data memory
 * and waits for their response, and drives the retirement trace.
 */

`timescale 1ns/1ps

module wb_stage import core_isa_pkg::*, core_pipe_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  input  ex_wb_pipe_t ex_wb_pipe_i,
  output logic        dmem_req_o,
  output word_t       dmem_addr_o,
  input  logic        dmem_rvalid_i,
  input  word_t       dmem_rdata_i,
  output logic        wb_ready_o,
  output word_t       wb_fw_o,
  output word_t       rf_data_o [32],
  output logic        wb_valid_o,
  output logic        wb_we_o,
  output rf_addr_t    wb_waddr_o,
  output word_t       wb_wdata_o
);

  word_t rf_q [1:31];
  logic  load_wb;
  logic  load_wait_q;
  logic  load_done;

  ////////////////////////////////////////
  // Load handshake
  ////////////////////////////////////////

  assign load_wb = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.lsu_en;

  // Set after the first request cycle, response is never earlier
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      load_wait_q <= 1'b0;
    end else begin
      load_wait_q <= load_wb && !load_done;
    end
  end

  assign load_done   = load_wb && load_wait_q && dmem_rvalid_i;
  // Request held steady until the response
  assign dmem_req_o  = load_wb;
  assign dmem_addr_o = ex_wb_pipe_i.result;
  assign wb_ready_o  = !load_wb || load_done;

  // Load data or ALU value, also the WB forward path
  assign wb_fw_o = ex_wb_pipe_i.lsu_en ? dmem_rdata_i : ex_wb_pipe_i.result;

  ////////////////////////////////////////
  // Retirement and register file
  ////////////////////////////////////////

  assign wb_valid_o = ex_wb_pipe_i.instr_valid && wb_ready_o;
  assign wb_we_o    = wb_valid_o && ex_wb_pipe_i.rf_we;
  assign wb_waddr_o = ex_wb_pipe_i.rf_waddr;
  assign wb_wdata_o = wb_fw_o;

  // Register 0 is hardwired
  assign rf_data_o[0] = '0;

  for (genvar i = 1; i < 32; i++) begin : gen_rf
    always_ff @(posedge clk) begin
      if (wb_we_o && (wb_waddr_o == rf_addr_t'(i))) begin
        rf_q[i] <= wb_wdata_o;
      end
    end
    assign rf_data_o[i] = rf_q[i];
  end

endmodule

//--- hdl/ex_stage.sv
/*
 * Execute stage. Owns the ID/EX and EX/WB registers and the ALU, which
 * also forms the load address. Holds while WB waits on memory.
 */

`timescale 1ns/1ps

module ex_stage import core_isa_pkg::*, core_pipe_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        id_valid_i,
  input  logic        rf_we_i,
  input  logic        lsu_en_i,
  input  rf_addr_t    rf_waddr_i,
  input  alu_op_e     alu_op_i,
  input  logic        rs2_re_i,
  input  word_t       operand_a_i,
  input  word_t       operand_b_i,
  input  word_t       imm_i,
  input  logic        deassert_we_i,
  input  logic        load_stall_i,
  input  logic        wb_ready_i,
  output id_ex_pipe_t id_ex_pipe_o,
  output ex_wb_pipe_t ex_wb_pipe_o,
  output word_t       ex_result_o
);

  id_ex_pipe_t id_ex_q;
  ex_wb_pipe_t ex_wb_q;
  word_t       alu_result;

  // ID/EX, bubble on load stall, hold while WB busy
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      id_ex_q.instr_valid <= 1'b0;
      id_ex_q.rf_we       <= 1'b0;
      id_ex_q.lsu_en      <= 1'b0;
    end else if (wb_ready_i) begin
      id_ex_q.instr_valid <= id_valid_i && !load_stall_i;
      // Illegal retires as a no-op
      id_ex_q.rf_we       <= rf_we_i && !deassert_we_i;
      id_ex_q.lsu_en      <= lsu_en_i && !deassert_we_i;
      id_ex_q.rf_waddr    <= rf_waddr_i;
      id_ex_q.alu_op      <= alu_op_i;
      id_ex_q.operand_a   <= operand_a_i;
      // Immediate replaces rs2 for I format
      id_ex_q.operand_b   <= rs2_re_i ? operand_b_i : imm_i;
    end
  end

  // ALU, load address is rs1 plus immediate through ADD
  always_comb begin
    case (id_ex_q.alu_op)
      ALU_SUB: alu_result = id_ex_q.operand_a - id_ex_q.operand_b;
      ALU_AND: alu_result = id_ex_q.operand_a & id_ex_q.operand_b;
      ALU_XOR: alu_result = id_ex_q.operand_a ^ id_ex_q.operand_b;
      default: alu_result = id_ex_q.operand_a + id_ex_q.operand_b;
    endcase
  end

  // EX/WB advances only when WB is ready
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ex_wb_q.instr_valid <= 1'b0;
      ex_wb_q.rf_we       <= 1'b0;
      ex_wb_q.lsu_en      <= 1'b0;
    end else if (wb_ready_i) begin
      ex_wb_q.instr_valid <= id_ex_q.instr_valid;
      ex_wb_q.rf_we       <= id_ex_q.rf_we;
      ex_wb_q.lsu_en      <= id_ex_q.lsu_en;
      ex_wb_q.rf_waddr    <= id_ex_q.rf_waddr;
      ex_wb_q.result      <= alu_result;
    end
  end

  assign id_ex_pipe_o = id_ex_q;
  assign ex_wb_pipe_o = ex_wb_q;
  assign ex_result_o  = alu_result;

endmodule

//--- hdl/operand_read_port.sv
/*
 * One source operand read port. Reads the register file and applies the
 * forwarding select. Instanced once per source operand in the top level.
 */

`timescale 1ns/1ps

module operand_read_port import core_isa_pkg::*, core_pipe_pkg::*; (
  input  rf_addr_t raddr_i,
  input  fwd_sel_e sel_i,
  input  word_t    rf_data_i [32],
  input  word_t    ex_fw_i,
  input  word_t    wb_fw_i,
  output word_t    operand_o
);

  word_t rf_rdata;

  // Register 0 reads as zero
  assign rf_rdata = (raddr_i == '0) ? '0 : rf_data_i[raddr_i];

  // Forwarding mux
  always_comb begin
    case (sel_i)
      SEL_FW_EX: operand_o = ex_fw_i;
      SEL_FW_WB: operand_o = wb_fw_i;
      default:   operand_o = rf_rdata;
    endcase
  end

endmodule

//--- hdl/bypass_ctrl.sv
/*
 * Hazard detection and operand forwarding control for the ID stage.
 * Compares ID reads with EX and WB writes, raises the load-use stall and
 * kills the write of illegal instructions.
 */

`timescale 1ns/1ps

module bypass_ctrl import core_isa_pkg::*, core_pipe_pkg::*; (
  input  logic [1:0]  rf_re_i,
  input  rf_addr_t    rf_raddr_i [2],
  input  logic        illegal_i,
  input  id_ex_pipe_t id_ex_pipe_i,
  input  ex_wb_pipe_t ex_wb_pipe_i,
  input  logic        wb_ready_i,
  output ctrl_byp_t   ctrl_byp_o
);

  logic [1:0] rd_ex_match;
  logic [1:0] rd_wb_match;
  logic       rf_we_ex;
  logic       rf_we_wb;
  logic       load_ex;
  logic       load_wb;

  // Qualified writes in EX and WB
  assign rf_we_ex = id_ex_pipe_i.instr_valid && id_ex_pipe_i.rf_we;
  assign rf_we_wb = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.rf_we;

  // Loads whose data is not yet there
  assign load_ex = id_ex_pipe_i.lsu_en;
  assign load_wb = ex_wb_pipe_i.lsu_en;

  ////////////////////////////////////////
  // Read/write address compare
  ////////////////////////////////////////

  for (genvar i = 0; i < 2; i++) begin : gen_match
    // Enabled nonzero read hitting the EX write
    assign rd_ex_match[i] = rf_re_i[i] && (rf_raddr_i[i] != '0) && rf_we_ex &&
                            (rf_raddr_i[i] == id_ex_pipe_i.rf_waddr);
    // Same against the WB write
    assign rd_wb_match[i] = rf_re_i[i] && (rf_raddr_i[i] != '0) && rf_we_wb &&
                            (rf_raddr_i[i] == ex_wb_pipe_i.rf_waddr);
  end

  ////////////////////////////////////////
  // Stall and write kill
  ////////////////////////////////////////

  always_comb begin
    ctrl_byp_o.load_stall  = 1'b0;
    ctrl_byp_o.deassert_we = illegal_i;

    // Load in EX, result not available before WB
    if (load_ex && |rd_ex_match) begin
      ctrl_byp_o.load_stall = 1'b1;
    end

    // Load in WB still waiting for its response
    if (!wb_ready_i && load_wb && |rd_wb_match) begin
      ctrl_byp_o.load_stall = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Forwarding selects
  ////////////////////////////////////////

  always_comb begin
    ctrl_byp_o.operand_a_fw_mux_sel = SEL_REGFILE;
    ctrl_byp_o.operand_b_fw_mux_sel = SEL_REGFILE;

    // WB first, EX overrides as the younger write
    if (rd_wb_match[0]) begin
      ctrl_byp_o.operand_a_fw_mux_sel = SEL_FW_WB;
    end
    if (rd_wb_match[1]) begin
      ctrl_byp_o.operand_b_fw_mux_sel = SEL_FW_WB;
    end

    if (rd_ex_match[0]) begin
      ctrl_byp_o.operand_a_fw_mux_sel = SEL_FW_EX;
    end
    if (rd_ex_match[1]) begin
      ctrl_byp_o.operand_b_fw_mux_sel = SEL_FW_EX;
    end
  end

endmodule

//--- hdl/instr_decoder.sv
/*
 * Decode of the instruction at the head of the fetch buffer.
 * Produces read ports, write port, ALU operation, load flag and immediate.
 */

`timescale 1ns/1ps

module instr_decoder import core_isa_pkg::*; (
  input  logic     instr_valid_i,
  input  word_t    instr_i,
  output logic [1:0] rf_re_o,
  output rf_addr_t rf_raddr_o [2],
  output rf_addr_t rf_waddr_o,
  output logic     rf_we_o,
  output logic     lsu_en_o,
  output logic     illegal_o,
  output alu_op_e  alu_op_o,
  output word_t    imm_o
);

  isa_word_u word;

  assign word = instr_i;

  // Register fields sit in the same place in both formats
  assign rf_raddr_o[0] = word.r.rs1;
  assign rf_raddr_o[1] = word.r.rs2;
  assign rf_waddr_o    = word.r.rd;

  // Sign-extended I immediate
  assign imm_o = {{20{word.i.imm12[11]}}, word.i.imm12};

  always_comb begin
    rf_re_o   = 2'b00;
    rf_we_o   = 1'b0;
    lsu_en_o  = 1'b0;
    illegal_o = 1'b0;
    alu_op_o  = ALU_ADD;

    if (instr_valid_i) begin
      case (word.r.opcode)
        OP_REG: begin
          rf_re_o = 2'b11;
          rf_we_o = 1'b1;
          case ({word.r.funct7, word.r.funct3})
            {F7_BASE, F3_ADD_SUB}: alu_op_o = ALU_ADD;
            {F7_SUB,  F3_ADD_SUB}: alu_op_o = ALU_SUB;
            {F7_BASE, F3_AND}:     alu_op_o = ALU_AND;
            {F7_BASE, F3_XOR}:     alu_op_o = ALU_XOR;
            default:               illegal_o = 1'b1;
          endcase
        end
        OP_IMM: begin
          // ADDI only
          rf_re_o   = 2'b01;
          rf_we_o   = 1'b1;
          illegal_o = (word.i.funct3 != F3_ADD_SUB);
        end
        OP_LOAD: begin
          // LW, address is rs1 plus immediate
          rf_re_o   = 2'b01;
          rf_we_o   = 1'b1;
          lsu_en_o  = 1'b1;
          illegal_o = (word.i.funct3 != F3_LW);
        end
        default: illegal_o = 1'b1;
      endcase

      // Register 0 never written
      if (word.r.rd == '0) begin
        rf_we_o = 1'b0;
      end
    end
  end

endmodule

//--- hdl/fetch_buffer.sv
/*
 * Credit-controlled instruction FIFO in front of decode. The sender starts
 * with FETCH_DEPTH credits and gets one back through credit_o per pop.
 */

`timescale 1ns/1ps

module fetch_buffer import core_isa_pkg::*; #(
  parameter int unsigned FETCH_DEPTH = 4
) (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  push_valid_i,
  input  word_t push_instr_i,
  input  logic  pop_i,
  output logic  head_valid_o,
  output word_t head_instr_o,
  output logic  credit_o
);

  localparam int unsigned PTR_W = $clog2(FETCH_DEPTH);
  localparam int unsigned CNT_W = $clog2(FETCH_DEPTH + 1);

  word_t            mem_q [FETCH_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             credit_q;

  // Wrap at FETCH_DEPTH, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FETCH_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Storage, no reset on payload
  always_ff @(posedge clk) begin
    if (push_valid_i) begin
      mem_q[wr_ptr_q] <= push_instr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      // One credit back per consumed entry
      credit_q <= pop_i;
      if (push_valid_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(push_valid_i) - CNT_W'(pop_i);
    end
  end

  // Head is visible the cycle after its push
  assign head_valid_o = (count_q != '0);
  assign head_instr_o = mem_q[rd_ptr_q];
  assign credit_o     = credit_q;

endmodule

//--- hdl/core_pipe_pkg.sv
/*
 * Pipeline-level types. Holds the ID/EX and EX/WB registers, the operand
 * forwarding select and the bypass controller output bundle.
 */

package core_pipe_pkg;

  // Operand source for each read port
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'd0,
    SEL_FW_EX   = 2'd1,
    SEL_FW_WB   = 2'd2
  } fwd_sel_e;

  ////////////////////////////////////////
  // Pipeline registers
  ////////////////////////////////////////

  // ID to EX
  typedef struct packed {
    logic                  instr_valid;
    logic                  rf_we;
    logic                  lsu_en;
    core_isa_pkg::rf_addr_t rf_waddr;
    core_isa_pkg::alu_op_e  alu_op;
    core_isa_pkg::word_t    operand_a;
    core_isa_pkg::word_t    operand_b;
  } id_ex_pipe_t;

  // EX to WB, result is the ALU value or the load address
  typedef struct packed {
    logic                  instr_valid;
    logic                  rf_we;
    logic                  lsu_en;
    core_isa_pkg::rf_addr_t rf_waddr;
    core_isa_pkg::word_t    result;
  } ex_wb_pipe_t;

  // Hazard and forwarding decisions
  typedef struct packed {
    logic     load_stall;
    logic     deassert_we;
    fwd_sel_e operand_a_fw_mux_sel;
    fwd_sel_e operand_b_fw_mux_sel;
  } ctrl_byp_t;

endpackage

//--- hdl/core_isa_pkg.sv
/*
 * Instruction set definitions for the three-stage integer pipeline.
 * Covers register and data types, opcodes, function codes and the two
 * views of a 32-bit instruction word used by the decoder.
 */

package core_isa_pkg;

  // Register index and data word
  typedef logic [4:0]  rf_addr_t;
  typedef logic [31:0] word_t;

  // Major opcodes in the low seven bits
  typedef enum logic [6:0] {
    OP_LOAD = 7'h03,
    OP_IMM  = 7'h13,
    OP_REG  = 7'h33
  } opcode_e;

  // ALU operations
  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_AND = 2'd2,
    ALU_XOR = 2'd3
  } alu_op_e;

  ////////////////////////////////////////
  // Function codes
  ////////////////////////////////////////

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [6:0] F7_BASE    = 7'h00;
  localparam logic [6:0] F7_SUB     = 7'h20;

  // Register-register format
  typedef struct packed {
    logic [6:0] funct7;
    rf_addr_t   rs2;
    rf_addr_t   rs1;
    logic [2:0] funct3;
    rf_addr_t   rd;
    opcode_e    opcode;
  } r_fmt_t;

  // Immediate format, shared by ADDI and LW
  typedef struct packed {
    logic [11:0] imm12;
    rf_addr_t    rs1;
    logic [2:0]  funct3;
    rf_addr_t    rd;
    opcode_e     opcode;
  } i_fmt_t;

  // Same word seen in both formats
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } isa_word_u;

endpackage
